// File: Bender.yml
package:
  name: prefetch_buffer

sources:
  - verilog/prefetch_pkg.sv
  - verilog/fetch_fifo.sv
  - verilog/prefetch_ctrl.sv
  - verilog/prefetch_buffer.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_wb_instr_mem.sv
      - testbench/prefetch_buffer_props.sv
      - testbench/tb_prefetch_buffer.sv

// File: flist.f
verilog/prefetch_pkg.sv
verilog/fetch_fifo.sv
verilog/prefetch_ctrl.sv
verilog/prefetch_buffer.sv
testbench/tb_clk_gen.sv
testbench/tb_wb_instr_mem.sv
testbench/prefetch_buffer_props.sv
testbench/tb_prefetch_buffer.sv

// File: testbench/prefetch_buffer_props.sv
// ==========================================================================
// FIFO use and bus stability checks, bound into the FIFO and the controller
// inputs that a binding does not use are tied low
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer_props
    import prefetch_pkg::*;
(
    input wire logic    clk_i,
    input wire logic    rst_ni,
    input wire logic    push_i,
    input wire logic    pop_i,
    input wire logic    full_i,
    input wire logic    empty_i,
    input wire wb_req_t req_i,
    input wire wb_rsp_t rsp_i
);

    // failures seen, summed up by the testbench
    int unsigned fail_cnt = 0;

    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_i)
        else begin
            $error("push into a full FIFO");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_i)
        else begin
            $error("pop from an empty FIFO");
            fail_cnt++;
        end

    // classic cycle: request and address held until ack
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_i.stb && !rsp_i.ack) |=> (req_i.cyc && req_i.stb && $stable(req_i.adr)))
        else begin
            $error("bus request changed before ack");
            fail_cnt++;
        end

endmodule

bind fetch_fifo prefetch_buffer_props u_fifo_props (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push_i),
    .pop_i   (pop_i),
    .full_i  (full_o),
    .empty_i (empty_o),
    .req_i   ('0),
    .rsp_i   ('0)
);

bind prefetch_ctrl prefetch_buffer_props u_bus_props (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (1'b0),
    .pop_i   (1'b0),
    .full_i  (1'b0),
    .empty_i (1'b0),
    .req_i   (wb_req_o),
    .rsp_i   (wb_rsp_i)
);

`default_nettype wire

// File: testbench/prefetch_stimulus.txt
// op arg target first_addr, hex; op 1 consume arg entries ready high, 2 toggling
// op 3 stall arg cycles, op 4 redirect with arg bit0 keep head, bit1 wait for a read
1 0000000C 00000000 00000000
2 00000008 00000000 00000000
3 0000001E 00000000 00000000
1 00000006 00000000 00000000
4 00000000 00001000 00001000
2 00000005 00000000 00000000
3 0000001E 00000000 00000000
4 00000001 00002000 00002000
1 00000006 00000000 00000000
4 00000000 00003000 00003000
4 00000002 00003400 00003400
2 00000007 00000000 00000000
4 00000000 00004000 00004000
4 00000003 00004800 00004800
1 00000008 00000000 00000000
0 00000000 00000000 00000000

// File: testbench/tb_clk_gen.sv
// ==========================================================================
// testbench clock of 10 ns, reset low over the first two rising edges
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // release 1 ns after the second edge, like every other input
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_prefetch_buffer.sv
// ==========================================================================
// prefetch buffer testbench, commands come from prefetch_stimulus.txt
// redirects are always issued with ready low
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_buffer
    import prefetch_pkg::*;
();

    localparam int unsigned TIMEOUT   = 200;
    localparam int unsigned MAX_CMDS  = 32;
    localparam logic [31:0] INSTR_PAT = 32'hA5A5_0000;

    logic         clk;
    logic         rst_n;
    redirect_t    redirect;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    logic         instr_ready;
    logic         instr_valid;
    fetch_entry_t instr;

    // four words per command: op, arg, target, first address
    logic [31:0] stim [MAX_CMDS*4];
    logic [31:0] exp_addr;
    // stream start after a kept head has been popped
    logic [31:0] after_head;
    logic        head_pending;
    int unsigned errors;
    int unsigned checks;

    tb_clk_gen u_clk (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    prefetch_buffer uut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .redirect_i    (redirect),
        .wb_rsp_i      (wb_rsp),
        .instr_ready_i (instr_ready),
        .wb_req_o      (wb_req),
        .instr_valid_o (instr_valid),
        .instr_o       (instr)
    );

    tb_wb_instr_mem #(
        .PATTERN (INSTR_PAT)
    ) u_mem (
        .clk_i  (clk),
        .rst_ni (rst_n),
        .req_i  (wb_req),
        .rsp_o  (wb_rsp)
    );

    // drive point, 1 ns after the edge, DUT outputs are settled here
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_entry();
        checks++;
        assert (instr.addr == exp_addr) else begin
            $display("** Error at %0t: instr_o.addr = %h, expected %h",
                     $time, instr.addr, exp_addr);
            errors++;
        end
        assert (instr.instr == (exp_addr ^ INSTR_PAT)) else begin
            $display("** Error at %0t: instr_o.instr = %h, expected %h",
                     $time, instr.instr, exp_addr ^ INSTR_PAT);
            errors++;
        end
        if (head_pending) begin
            head_pending = 1'b0;
            exp_addr     = after_head;
        end else begin
            exp_addr = exp_addr + 32'd4;
        end
    endtask

    task automatic consume(input int unsigned n, input bit toggle);
        int unsigned got;
        int unsigned idle;
        bit          ready;
        got   = 0;
        idle  = 0;
        ready = 1'b0;
        while (got < n && idle < TIMEOUT) begin
            step();
            ready       = toggle ? ~ready : 1'b1;
            instr_ready = ready;
            // pop happens at the coming edge
            if (instr_valid && ready) begin
                check_entry();
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        step();
        instr_ready = 1'b0;
        assert (got == n) else begin
            $display("timeout: only %0d of %0d entries arrived", got, n);
            errors++;
        end
    endtask

    task automatic stall(input int unsigned n);
        int unsigned acks;
        acks        = 0;
        instr_ready = 1'b0;
        repeat (n) begin
            step();
            if (wb_rsp.ack) begin
                acks++;
            end
        end
        checks++;
        assert (acks <= FETCH_DEPTH) else begin
            $display("** Error at %0t: wb_rsp_i.ack count = %0d, expected <= %0d",
                     $time, acks, FETCH_DEPTH);
            errors++;
        end
    endtask

    // mode bit0 keeps the head, bit1 waits for a read in flight first
    task automatic issue_redirect(input logic [31:0] mode, input logic [31:0] tgt,
                                  input logic [31:0] first_addr);
        int unsigned w;
        w           = 0;
        instr_ready = 1'b0;
        step();
        if (mode[1]) begin
            while (!(wb_req.cyc && !wb_rsp.ack) && w < TIMEOUT) begin
                step();
                w++;
            end
            assert (w < TIMEOUT) else begin
                $display("timeout: no bus read in flight to redirect against");
                errors++;
            end
        end
        // with ready low the present head is the one still expected
        head_pending = mode[0] && instr_valid;
        if (head_pending) begin
            after_head = first_addr;
        end else begin
            exp_addr = first_addr;
        end
        redirect = '{valid: 1'b1, keep_head: mode[0], target: tgt};
        step();
        redirect = '0;
    endtask

    initial begin
        int unsigned idx;
        int unsigned w;
        int unsigned errs_before;
        logic [31:0] op;
        logic [31:0] arg;
        redirect     = '0;
        instr_ready  = 1'b0;
        errors       = 0;
        checks       = 0;
        head_pending = 1'b0;
        exp_addr     = BOOT_ADDR;
        after_head   = '0;
        for (idx = 0; idx < MAX_CMDS * 4; idx++) begin
            stim[idx] = '0;
        end
        $readmemh("testbench/prefetch_stimulus.txt", stim);
        w = 0;
        while (!rst_n && w < TIMEOUT) begin
            step();
            w++;
        end
        idx = 0;
        // op 0 ends the list
        while (idx < MAX_CMDS && stim[idx*4] != 32'd0) begin
            op          = stim[idx*4];
            arg         = stim[idx*4+1];
            errs_before = errors;
            case (op)
                32'd1:   consume(arg, 1'b0);
                32'd2:   consume(arg, 1'b1);
                32'd3:   stall(arg);
                32'd4:   issue_redirect(arg, stim[idx*4+2], stim[idx*4+3]);
                default: begin
                    $display("unknown command %0h in entry %0d", op, idx);
                    errors++;
                end
            endcase
            $display("command %0d op %0h arg %0h: %s", idx, op, arg,
                     (errors == errs_before) ? "ok" : "failed");
            idx++;
        end
        // concurrent checks count their own failures
        errors = errors + uut.u_fifo.u_fifo_props.fail_cnt
                        + uut.u_ctrl.u_bus_props.fail_cnt;
        $display("commands %0d, entries checked %0d, errors %0d", idx, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_wb_instr_mem.sv
// ==========================================================================
// Wishbone classic read slave, data is the address XOR PATTERN
// 0 to 3 wait states per read, ack is registered and lasts one cycle
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_wb_instr_mem
    import prefetch_pkg::*;
#(
    parameter logic [31:0] PATTERN = 32'hA5A5_0000
) (
    input  wire logic    clk_i,
    input  wire logic    rst_ni,
    input  wire wb_req_t req_i,
    output wb_rsp_t      rsp_o
);

    integer     seed = 32'h7c34_6dc3;
    // wait states left for the read in progress
    logic [1:0] wait_q;
    logic       active_q;
    logic [1:0] waits;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_o    <= '0;
            wait_q   <= '0;
            active_q <= 1'b0;
        end else begin
            rsp_o.ack <= 1'b0;
            // cycle after an ack belongs to no read
            if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
                if (active_q) begin
                    waits = wait_q;
                end else begin
                    waits = 2'($random(seed));
                end
                if (waits == 2'd0) begin
                    rsp_o.ack <= 1'b1;
                    rsp_o.dat <= req_i.adr ^ PATTERN;
                    active_q  <= 1'b0;
                end else begin
                    wait_q   <= waits - 2'd1;
                    active_q <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_fifo.sv
// ==========================================================================
// circular buffer of fetch entries, DEPTH must be at least 1
// push while full and pop while empty are ignored
// keep-head flush drops the head too if it is popped in the same cycle
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo
    import prefetch_pkg::*;
#(
    parameter bit          FALL_THROUGH = 1'b0,
    parameter int unsigned DEPTH        = 4
) (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_ni,
    input  wire logic                                     flush_i,
    input  wire logic                                     flush_but_first_i,
    input  wire logic                                     push_i,
    input  wire fetch_entry_t                             data_i,
    input  wire logic                                     pop_i,
    output logic                                          full_o,
    output logic                                          empty_o,
    output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1):0]    cnt_o,
    output fetch_entry_t                                  data_o
);

    // pointer width, one bit less than the count
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // storage, written only on an accepted push
    fetch_entry_t mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   cnt_q;
    logic [PTR_W:0]   cnt_d;

    // accepted push and pop after the full and empty checks
    logic wr_en;
    logic rd_en;
    // word goes straight through an empty FIFO and leaves at once
    logic bypass;
    // head survives a keep-head flush
    logic head_kept;

    // advance a pointer with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign cnt_o   = cnt_q;
    assign full_o  = (cnt_q == (PTR_W + 1)'(DEPTH));
    // in fall-through mode a push makes an empty FIFO look non-empty
    assign empty_o = (cnt_q == '0) & ~(FALL_THROUGH & push_i);

    assign bypass    = FALL_THROUGH && (cnt_q == '0) && push_i && pop_i;
    assign wr_en     = push_i & ~full_o & ~bypass;
    assign rd_en     = pop_i & ~empty_o & ~bypass;
    assign head_kept = (cnt_q != '0) & ~rd_en;

    // head entry, or the incoming word when passing through
    always_comb begin
        data_o = mem_q[rd_ptr_q];
        if (FALL_THROUGH && (cnt_q == '0) && push_i) begin
            data_o = data_i;
        end
    end

    // push and pop together leave the count alone
    always_comb begin
        unique case ({wr_en, rd_en})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            default: cnt_d = cnt_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_but_first_i) begin
            if (head_kept) begin
                // head stays in place, everything behind it goes
                wr_ptr_q <= ptr_inc(rd_ptr_q);
                cnt_q    <= (PTR_W + 1)'(1);
            end else begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                cnt_q    <= '0;
            end
        end else begin
            if (wr_en) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            cnt_q <= cnt_d;
        end
    end

    // a write in a flush cycle is harmless, the pointers move past it
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/prefetch_buffer.sv
// ==========================================================================
// instruction prefetch buffer top level
// core pops with instr_valid_o and instr_ready_i, entries appear one cycle
// after their bus ack; redirect with ready low to keep the head safely
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer
    import prefetch_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire redirect_t redirect_i,
    input  wire wb_rsp_t   wb_rsp_i,
    input  wire logic      instr_ready_i,
    output wb_req_t        wb_req_o,
    output logic           instr_valid_o,
    output fetch_entry_t   instr_o
);

    logic [FETCH_CNT_W-1:0] fifo_cnt;
    fetch_entry_t           push_entry;
    logic                   push;
    logic                   pop;
    logic                   flush;
    logic                   flush_keep;
    logic                   fifo_empty;

    // core handshake
    assign instr_valid_o = ~fifo_empty;
    assign pop           = instr_valid_o & instr_ready_i;

    prefetch_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .redirect_i   (redirect_i),
        .wb_rsp_i     (wb_rsp_i),
        .fifo_cnt_i   (fifo_cnt),
        .wb_req_o     (wb_req_o),
        .push_o       (push),
        .entry_o      (push_entry),
        .flush_o      (flush),
        .flush_keep_o (flush_keep)
    );

    // full is not needed here, the controller never overfills
    fetch_fifo #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (FETCH_DEPTH)
    ) u_fifo (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush),
        .flush_but_first_i (flush_keep),
        .push_i            (push),
        .data_i            (push_entry),
        .pop_i             (pop),
        .full_o            (),
        .empty_o           (fifo_empty),
        .cnt_o             (fifo_cnt),
        .data_o            (instr_o)
    );

endmodule

`default_nettype wire

// File: verilog/prefetch_ctrl.sv
// ==========================================================================
// Wishbone classic read master for instruction prefetch
// one read in flight, started only if its word will fit in the FIFO
// redirect_i.valid must be a single-cycle pulse
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module prefetch_ctrl
    import prefetch_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire redirect_t              redirect_i,
    input  wire wb_rsp_t                wb_rsp_i,
    input  wire logic [FETCH_CNT_W-1:0] fifo_cnt_i,
    output wb_req_t                     wb_req_o,
    output logic                        push_o,
    output fetch_entry_t                entry_o,
    output logic                        flush_o,
    output logic                        flush_keep_o
);

    // next address to fetch
    logic [31:0] fetch_addr_q;
    logic [31:0] fetch_addr_d;
    // address of the read on the bus
    logic [31:0] adr_q;
    // read in flight
    logic        busy_q;
    // in-flight read belongs to the stream before a redirect
    logic        stale_q;

    logic                   ack_now;
    logic                   idle_next;
    logic                   room;
    logic [FETCH_CNT_W-1:0] cnt_after;

    // read ends this cycle
    assign ack_now   = busy_q & wb_rsp_i.ack;
    // bus is free for a new read at the coming edge
    assign idle_next = ~busy_q | ack_now;

    // a word acked together with a redirect is from the old stream
    assign push_o = ack_now & ~stale_q & ~redirect_i.valid;

    assign entry_o.addr  = adr_q;
    assign entry_o.instr = wb_rsp_i.dat;

    // flush requests go straight to the FIFO
    assign flush_o      = redirect_i.valid & ~redirect_i.keep_head;
    assign flush_keep_o = redirect_i.valid & redirect_i.keep_head;

    // count seen by the next read, pops ignored so the check stays safe
    assign cnt_after = fifo_cnt_i + FETCH_CNT_W'(push_o);
    // after a redirect at most the head is left, so there is always room
    assign room = redirect_i.valid | (cnt_after < FETCH_CNT_W'(FETCH_DEPTH));

    always_comb begin
        fetch_addr_d = fetch_addr_q;
        if (redirect_i.valid) begin
            fetch_addr_d = redirect_i.target;
        end else if (push_o) begin
            // step over the word just delivered
            fetch_addr_d = fetch_addr_q + 32'd4;
        end
    end

    // cyc and stb move together, adr only changes when a read starts
    assign wb_req_o.cyc = busy_q;
    assign wb_req_o.stb = busy_q;
    assign wb_req_o.adr = adr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_addr_q <= BOOT_ADDR;
            adr_q        <= '0;
            busy_q       <= 1'b0;
            stale_q      <= 1'b0;
        end else begin
            fetch_addr_q <= fetch_addr_d;
            if (idle_next) begin
                busy_q <= room;
                if (room) begin
                    adr_q <= fetch_addr_d;
                end
            end
            // stale only while the old read is still waiting for its ack
            if (ack_now) begin
                stale_q <= 1'b0;
            end else if (redirect_i.valid && busy_q) begin
                stale_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/prefetch_pkg.sv
// ==========================================================================
// shared types and constants of the instruction prefetch buffer
// bus is Wishbone classic, read only, one read in flight, word aligned
// ==========================================================================
`default_nettype none

package prefetch_pkg;

    // fetch FIFO depth and the width of its occupancy count
    localparam int unsigned FETCH_DEPTH = 4;
    localparam int unsigned FETCH_CNT_W = $clog2(FETCH_DEPTH) + 1;

    // first fetch address after reset
    localparam logic [31:0] BOOT_ADDR = 32'h0000_0080;

    // master side of the bus
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

    // slave side of the bus
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // branch redirect from the core
    // keep_head spares the entry the core is still looking at
    typedef struct packed {
        logic        valid;
        logic        keep_head;
        logic [31:0] target;
    } redirect_t;

    // one fetched word and where it came from
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] instr;
    } fetch_entry_t;

endpackage

`default_nettype wire
